/* list.f */
+incdir+hw
hw/vtp_client_pkg.sv
hw/vtp_tlb_pkg.sv
hw/vtp_tlb_if.sv
hw/vtp_fifo.sv
hw/vtp_req_merge.sv
hw/vtp_tlb.sv
hw/vtp_walk.sv
hw/vtp_svc.sv
verification/vtp_svc_checker.sv
verification/vtp_svc_tb.sv

/* Makefile */
TOP := vtp_svc_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f hw/*.sv hw/*.svh verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

/* verification/vtp_svc_tb.sv */
`timescale 1ns/1ps
`include "vtp_macros.svh"

module vtp_svc_tb
    import vtp_client_pkg::*;
();

    // Six directed tests of at most a few hundred cycles each, large margin on top
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int TAGS = 1 << `VTP_TAG_BITS;
    localparam int RANDOM_LOOKUPS = 40;
    localparam int RANDOM_PAGES = 12;

    logic                    clk = 1'b0;
    logic                    reset;

    // Client side
    logic [`VTP_N_PORTS-1:0] lookup_en;
    t_vtp_lookup_req         lookup_req [`VTP_N_PORTS];
    logic [`VTP_N_PORTS-1:0] lookup_rdy;
    logic [`VTP_N_PORTS-1:0] rsp_valid;
    t_vtp_lookup_rsp         rsp_data;

    // Page-walk bus
    logic                    walk_req_en;
    t_vtp_va_page            walk_req_va;
    t_vtp_port_idx           walk_req_port;
    t_vtp_tag                walk_req_tag;
    logic                    walk_req_rdy;
    logic                    walk_rsp_en = 1'b0;
    t_vtp_va_page            walk_rsp_va = '0;
    t_vtp_pa_page            walk_rsp_pa = '0;
    t_vtp_port_idx           walk_rsp_port = '0;
    t_vtp_tag                walk_rsp_tag = '0;

    // Scoreboard, outstanding VA keyed by port and tag
    t_vtp_va_page            pending [int];
    int                      cycle = 0;
    int                      walk_count = 0;
    t_vtp_routed_req         walk_log [$];

    // Walk model, requests waiting for their answer cycle
    t_vtp_routed_req         walk_q [$];
    int                      walk_due [$];

    vtp_svc dut0 (.*);

    initial
    begin
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp)
        else abort_run($sformatf("FAIL t=%0t %s got 0x%0h expected 0x%0h",
                                 $time, name, got, exp));
    endtask

    // Translation rule of the walk model
    function automatic t_vtp_pa_page mapped_pa(input t_vtp_va_page va);
        return t_vtp_pa_page'(va + 20'h100);
    endfunction

    function automatic int key_of(input int port, input int tag);
        return port * TAGS + tag;
    endfunction

    // Drive one request now, at a falling edge with lookup_rdy high
    task automatic issue(input int port, input t_vtp_va_page va, input int tag);
        assert (!pending.exists(key_of(port, tag)))
        else abort_run("Port and tag reused while the earlier request is outstanding");
        lookup_en[port] = 1'b1;
        lookup_req[port].page_va = va;
        lookup_req[port].tag = t_vtp_tag'(tag);
        pending[key_of(port, tag)] = va;
        @(negedge clk);
        lookup_en[port] = 1'b0;
    endtask

    task automatic send(input int port, input t_vtp_va_page va, input int tag);
        while (!lookup_rdy[port])
        begin
            @(negedge clk);
        end
        issue(port, va, tag);
    endtask

    // Global timeout bounds this loop
    task automatic wait_all_answered();
        while (pending.size() != 0)
        begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    // ======================================================================
    // Cycle count, walk request capture and timeout
    // ======================================================================

    always @(posedge clk)
    begin
        t_vtp_routed_req wr;
        if (!reset && walk_req_en)
        begin
            wr.req.page_va = walk_req_va;
            wr.req.tag = walk_req_tag;
            wr.port = walk_req_port;
            walk_log.push_back(wr);
            walk_q.push_back(wr);
            // Answer 3 to 6 cycles later
            walk_due.push_back(cycle + 3 + int'($urandom % 4));
            walk_count++;
        end
        cycle++;
        assert (cycle < TIMEOUT_CYCLES)
        else abort_run("Timeout, the tests did not finish within the cycle limit");
    end

    // Walk responses in request order, port and tag echoed
    always @(negedge clk)
    begin
        t_vtp_routed_req wr;
        walk_rsp_en = 1'b0;
        if (walk_q.size() != 0 && walk_due[0] <= cycle)
        begin
            wr = walk_q.pop_front();
            void'(walk_due.pop_front());
            walk_rsp_en = 1'b1;
            walk_rsp_va = wr.req.page_va;
            walk_rsp_pa = mapped_pa(wr.req.page_va);
            walk_rsp_port = wr.port;
            walk_rsp_tag = wr.req.tag;
        end
    end

    // Client responses checked against the scoreboard
    always @(posedge clk)
    begin
        int port;
        int key;
        if (!reset && rsp_valid != '0)
        begin
            port = 0;
            for (int p = 0; p < `VTP_N_PORTS; p++)
            begin
                if (rsp_valid[p])
                begin
                    port = p;
                end
            end
            key = key_of(port, int'(rsp_data.tag));
            assert (pending.exists(key))
            else abort_run($sformatf("Response on port %0d tag %0d matches no request",
                                     port, rsp_data.tag));
            expect_value("rsp_data.page_pa", rsp_data.page_pa, mapped_pa(pending[key]));
            pending.delete(key);
        end
    end

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic test_reset_idle();
        repeat (8)
        begin
            expect_value("rsp_valid", rsp_valid, 0);
            expect_value("walk_req_en", walk_req_en, 0);
            expect_value("lookup_rdy", lookup_rdy, {`VTP_N_PORTS{1'b1}});
            @(negedge clk);
        end
    endtask

    task automatic test_miss_then_hit();
        int walks_before;
        walks_before = walk_count;
        send(0, 20'h00123, 1);
        wait_all_answered();
        expect_value("walk request count", walk_count, walks_before + 1);
        expect_value("walk_req_va", walk_log[walks_before].req.page_va, 20'h00123);
        expect_value("walk_req_port", walk_log[walks_before].port, 0);
        expect_value("walk_req_tag", walk_log[walks_before].req.tag, 1);
        // Same page again must hit
        send(0, 20'h00123, 2);
        wait_all_answered();
        expect_value("walk request count", walk_count, walks_before + 1);
    endtask

    task automatic test_port_routing();
        int walks_before;
        walks_before = walk_count;
        // First pass misses, second pass hits
        for (int pass = 0; pass < 2; pass++)
        begin
            while (lookup_rdy != {`VTP_N_PORTS{1'b1}})
            begin
                @(negedge clk);
            end
            lookup_req[0].page_va = 20'h00200;
            lookup_req[0].tag = t_vtp_tag'(3 + 2 * pass);
            lookup_req[1].page_va = 20'h00301;
            lookup_req[1].tag = t_vtp_tag'(4 + 2 * pass);
            pending[key_of(0, 3 + 2 * pass)] = 20'h00200;
            pending[key_of(1, 4 + 2 * pass)] = 20'h00301;
            lookup_en = '1;
            @(negedge clk);
            lookup_en = '0;
            wait_all_answered();
        end
        expect_value("walk request count", walk_count, walks_before + 2);
    endtask

    task automatic test_conflict_eviction();
        t_vtp_va_page seq [3];
        int           walks_before;
        // Both pages map to set 5
        seq[0] = 20'h01005;
        seq[1] = 20'h02005;
        seq[2] = 20'h01005;
        for (int i = 0; i < 3; i++)
        begin
            walks_before = walk_count;
            send(1, seq[i], 8 + i);
            wait_all_answered();
            expect_value("walk request count", walk_count, walks_before + 1);
            expect_value("walk_req_va", walk_log[walks_before].req.page_va, seq[i]);
        end
    endtask

    task automatic test_back_pressure();
        int   sent;
        int   port;
        int   walks_before;
        logic dropped;
        walks_before = walk_count;
        sent = 0;
        dropped = 1'b0;
        walk_req_rdy = 1'b0;
        // Fresh pages, every one a miss
        while (!dropped && sent < `VTP_N_PORTS * TAGS)
        begin
            port = sent % `VTP_N_PORTS;
            if (!lookup_rdy[port])
            begin
                dropped = 1'b1;
            end
            else
            begin
                issue(port, 20'h10000 + t_vtp_va_page'(sent), sent / `VTP_N_PORTS);
                sent++;
            end
        end
        assert (dropped)
        else abort_run("lookup_rdy never dropped while the walk bus was held off");
        repeat (10) @(negedge clk);
        expect_value("walk request count", walk_count, walks_before);
        walk_req_rdy = 1'b1;
        wait_all_answered();
        expect_value("walk request count", walk_count, walks_before + sent);
    endtask

    task automatic test_random_stream();
        t_vtp_va_page pool [RANDOM_PAGES];
        int           port;
        int           tag;
        int           page_sel;
        int           walks_idle;
        // Stride 20 puts three pages on each of four sets
        for (int k = 0; k < RANDOM_PAGES; k++)
        begin
            pool[k] = 20'h0A000 + t_vtp_va_page'(k * 20);
        end
        for (int n = 0; n < RANDOM_LOOKUPS; n++)
        begin
            port = int'($urandom % `VTP_N_PORTS);
            page_sel = int'($urandom % RANDOM_PAGES);
            // Walk bus ready while waiting, so outstanding misses can drain
            walk_req_rdy = 1'b1;
            tag = -1;
            while (tag < 0)
            begin
                for (int t = TAGS - 1; t >= 0; t--)
                begin
                    if (!pending.exists(key_of(port, t)))
                    begin
                        tag = t;
                    end
                end
                if (tag < 0)
                begin
                    @(negedge clk);
                end
            end
            while (!lookup_rdy[port])
            begin
                @(negedge clk);
            end
            // Short random hold-off of the walk bus around this request
            walk_req_rdy = ($urandom % 4 != 0);
            issue(port, pool[page_sel], tag);
            if ($urandom % 4 == 0)
            begin
                @(negedge clk);
            end
        end
        walk_req_rdy = 1'b1;
        wait_all_answered();
        walks_idle = walk_count;
        repeat (20) @(negedge clk);
        // No late walk request once every lookup is answered
        expect_value("walk request count", walk_count, walks_idle);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial
    begin
        void'($urandom(20));
        reset = 1'b1;
        lookup_en = '0;
        for (int p = 0; p < `VTP_N_PORTS; p++)
        begin
            lookup_req[p] = '0;
        end
        walk_req_rdy = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        test_reset_idle();
        test_miss_then_hit();
        test_port_routing();
        test_conflict_eviction();
        test_back_pressure();
        test_random_stream();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* verification/vtp_svc_checker.sv */
`timescale 1ns/1ps
`include "vtp_macros.svh"

// Protocol checks on the service's top-level ports
module vtp_svc_checker
(
    input logic                    clk,
    input logic                    reset,
    input logic [`VTP_N_PORTS-1:0] lookup_en,
    input logic [`VTP_N_PORTS-1:0] lookup_rdy,
    input logic [`VTP_N_PORTS-1:0] rsp_valid,
    input logic                    walk_req_en,
    input logic                    walk_req_rdy
);

    // At most one client answered per cycle
    a_rsp_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(rsp_valid))
        else $error("rsp_valid has more than one bit set");

    // Walk request is a single-cycle pulse
    a_walk_pulse: assert property (@(posedge clk) disable iff (reset)
        walk_req_en |=> !walk_req_en)
        else $error("walk_req_en high in two consecutive cycles");

    a_walk_rdy: assert property (@(posedge clk) disable iff (reset)
        walk_req_en |-> walk_req_rdy)
        else $error("walk_req_en high while walk_req_rdy is low");

    // Clients only push while there is room
    a_lookup_rdy: assert property (@(posedge clk) disable iff (reset)
        (lookup_en & ~lookup_rdy) == '0)
        else $error("lookup_en high on a port whose lookup_rdy is low");

    a_reset_quiet: assert property (@(posedge clk) reset |=> (rsp_valid == '0))
        else $error("rsp_valid high in the cycle after reset");

endmodule

bind vtp_svc vtp_svc_checker chk0 (
    .clk(clk),
    .reset(reset),
    .lookup_en(lookup_en),
    .lookup_rdy(lookup_rdy),
    .rsp_valid(rsp_valid),
    .walk_req_en(walk_req_en),
    .walk_req_rdy(walk_req_rdy)
);

/* hw/vtp_svc.sv */
`timescale 1ns/1ps
`include "vtp_macros.svh"

// Address translation service, top level
module vtp_svc
    import vtp_client_pkg::*;
    import vtp_tlb_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    // Client ports
    input  logic [`VTP_N_PORTS-1:0] lookup_en,
    input  t_vtp_lookup_req         lookup_req [`VTP_N_PORTS],
    output logic [`VTP_N_PORTS-1:0] lookup_rdy,
    output logic [`VTP_N_PORTS-1:0] rsp_valid,
    output t_vtp_lookup_rsp         rsp_data,

    // Page-walk request bus
    output logic                    walk_req_en,
    output t_vtp_va_page            walk_req_va,
    output t_vtp_port_idx           walk_req_port,
    output t_vtp_tag                walk_req_tag,
    input  logic                    walk_req_rdy,

    // Page-walk responses
    input  logic                    walk_rsp_en,
    input  t_vtp_va_page            walk_rsp_va,
    input  t_vtp_pa_page            walk_rsp_pa,
    input  t_vtp_port_idx           walk_rsp_port,
    input  t_vtp_tag                walk_rsp_tag
);

    logic            req_valid;
    t_vtp_routed_req req;
    logic            lookup_go;

    logic            reqf_af;
    logic            resf_af;
    logic            resf_ne;
    t_vtp_routed_req head_req;
    t_vtp_tlb_result head_res;
    t_vtp_tlb_result tlb_result;

    logic            do_miss;
    logic            do_hit;
    logic            miss_ready;

    logic            walk_rsp_valid;
    t_vtp_lookup_rsp walk_rsp;
    t_vtp_port_idx   walk_rsp_port_q;

    vtp_tlb_if tlb_bus ();

    // ==================================================================
    // Request merge and TLB
    // ==================================================================

    vtp_req_merge merge (
        .clk,
        .reset,
        .lookup_en,
        .lookup_req,
        .lookup_rdy,
        .req_valid,
        .req,
        .req_ready(lookup_go)
    );

    vtp_tlb tlb (
        .clk,
        .reset,
        .tlb(tlb_bus)
    );

    // Lookup only with room for every result still in the pipeline
    assign lookup_go = req_valid && !reqf_af && !resf_af;
    assign tlb_bus.lookup_en = lookup_go;
    assign tlb_bus.lookup_va = req.req.page_va;

    // ==================================================================
    // TLB stage FIFOs, requests and results kept in step
    // ==================================================================

    vtp_fifo #(
        .t_payload(t_vtp_routed_req),
        .DEPTH(`VTP_STAGE_FIFO_DEPTH),
        .AF_SLACK(2)
    ) req_fifo (
        .clk,
        .reset,
        .enq_en(lookup_go),
        .enq_data(req),
        .not_full(),
        .almost_full(reqf_af),
        .deq_en(do_miss || do_hit),
        .first(head_req),
        .not_empty()
    );

    // Result lands two cycles after its lookup
    assign tlb_result.page_pa = tlb_bus.rsp_pa;
    assign tlb_result.hit = tlb_bus.rsp_hit;

    vtp_fifo #(
        .t_payload(t_vtp_tlb_result),
        .DEPTH(`VTP_STAGE_FIFO_DEPTH),
        .AF_SLACK(2)
    ) res_fifo (
        .clk,
        .reset,
        .enq_en(tlb_bus.rsp_hit || tlb_bus.rsp_miss),
        .enq_data(tlb_result),
        .not_full(),
        .almost_full(resf_af),
        .deq_en(do_miss || do_hit),
        .first(head_res),
        .not_empty(resf_ne)
    );

    // Misses to the walker, hits wait while the walker answers
    assign do_miss = resf_ne && !head_res.hit && miss_ready;
    assign do_hit = resf_ne && head_res.hit && !walk_rsp_valid;

    vtp_walk walk (
        .clk,
        .reset,
        .miss_valid(do_miss),
        .miss(head_req),
        .miss_ready,
        .walk_req_en,
        .walk_req_va,
        .walk_req_port,
        .walk_req_tag,
        .walk_req_rdy,
        .walk_rsp_en,
        .walk_rsp_va,
        .walk_rsp_pa,
        .walk_rsp_port,
        .walk_rsp_tag,
        .walk_rsp_valid,
        .walk_rsp,
        .walk_rsp_port_q,
        .tlb(tlb_bus)
    );

    // ==================================================================
    // Client responses
    // ==================================================================

    // One-hot valid on the requesting port, walker wins
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= '0;
        end
        else
        begin
            rsp_valid <= '0;
            if (walk_rsp_valid)
            begin
                rsp_valid[walk_rsp_port_q] <= 1'b1;
            end
            else if (do_hit)
            begin
                rsp_valid[head_req.port] <= 1'b1;
            end
        end
    end

    // Shared response data
    always_ff @(posedge clk)
    begin
        if (walk_rsp_valid)
        begin
            rsp_data <= walk_rsp;
        end
        else
        begin
            rsp_data.page_pa <= head_res.page_pa;
            rsp_data.tag <= head_req.req.tag;
        end
    end

endmodule

/* hw/vtp_walk.sv */
`timescale 1ns/1ps
`include "vtp_macros.svh"

// Miss queue, page-walk requester and walk response handling
module vtp_walk
    import vtp_client_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    // Misses from the TLB stage
    input  logic            miss_valid,
    input  t_vtp_routed_req miss,
    output logic            miss_ready,

    // Page-walk request bus
    output logic            walk_req_en,
    output t_vtp_va_page    walk_req_va,
    output t_vtp_port_idx   walk_req_port,
    output t_vtp_tag        walk_req_tag,
    input  logic            walk_req_rdy,

    // Page-walk responses, port and tag echoed
    input  logic            walk_rsp_en,
    input  t_vtp_va_page    walk_rsp_va,
    input  t_vtp_pa_page    walk_rsp_pa,
    input  t_vtp_port_idx   walk_rsp_port,
    input  t_vtp_tag        walk_rsp_tag,

    // Registered response toward the client
    output logic            walk_rsp_valid,
    output t_vtp_lookup_rsp walk_rsp,
    output t_vtp_port_idx   walk_rsp_port_q,

    vtp_tlb_if.fill         tlb
);

    logic            head_valid;
    t_vtp_routed_req head;
    logic            issued_q;

    // Misses wait here so hits keep flowing past them
    vtp_fifo #(
        .t_payload(t_vtp_routed_req),
        .DEPTH(`VTP_WALK_FIFO_DEPTH),
        .AF_SLACK(1)
    ) miss_fifo (
        .clk,
        .reset,
        .enq_en(miss_valid),
        .enq_data(miss),
        .not_full(miss_ready),
        .almost_full(),
        .deq_en(walk_req_en),
        .first(head),
        .not_empty(head_valid)
    );

    // Single-cycle pulse, never back to back, only while the bus is ready
    assign walk_req_en = head_valid && walk_req_rdy && !issued_q;
    assign walk_req_va = head.req.page_va;
    assign walk_req_port = head.port;
    assign walk_req_tag = head.req.tag;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            issued_q <= 1'b0;
            walk_rsp_valid <= 1'b0;
            tlb.fill_en <= 1'b0;
        end
        else
        begin
            issued_q <= walk_req_en;
            // Client response and TLB fill in the same cycle
            walk_rsp_valid <= walk_rsp_en;
            tlb.fill_en <= walk_rsp_en;
        end
    end

    always_ff @(posedge clk)
    begin
        walk_rsp.page_pa <= walk_rsp_pa;
        walk_rsp.tag <= walk_rsp_tag;
        walk_rsp_port_q <= walk_rsp_port;
        tlb.fill_va <= walk_rsp_va;
        tlb.fill_pa <= walk_rsp_pa;
    end

endmodule

/* hw/vtp_tlb.sv */
`timescale 1ns/1ps
`include "vtp_macros.svh"

// Direct-mapped TLB
// Stage 1 reads the entry, stage 2 compares the tag and reports
module vtp_tlb
    import vtp_tlb_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    vtp_tlb_if.server tlb
);

    t_vtp_tlb_entry entries [`VTP_TLB_SETS];

    logic           s1_valid;
    t_vtp_tlb_entry s1_entry;
    t_vtp_tlb_tag   s1_tag;
    logic           s1_match;

    // Fill overwrites the indexed entry, reset invalidates all
    // A fill is seen by lookups starting the following cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `VTP_TLB_SETS; i++)
            begin
                entries[i].valid <= 1'b0;
            end
        end
        else if (tlb.fill_en)
        begin
            entries[vtp_tlb_index(tlb.fill_va)] <= '{
                valid:   1'b1,
                tag:     vtp_tlb_tag_of(tlb.fill_va),
                page_pa: tlb.fill_pa
            };
        end
    end

    // Stage 1 read
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= tlb.lookup_en;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_entry <= entries[vtp_tlb_index(tlb.lookup_va)];
        s1_tag <= vtp_tlb_tag_of(tlb.lookup_va);
    end

    assign s1_match = s1_entry.valid && (s1_entry.tag == s1_tag);

    // Stage 2 result, exactly one of hit or miss per lookup
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tlb.rsp_hit <= 1'b0;
            tlb.rsp_miss <= 1'b0;
        end
        else
        begin
            tlb.rsp_hit <= s1_valid && s1_match;
            tlb.rsp_miss <= s1_valid && !s1_match;
        end
    end

    always_ff @(posedge clk)
    begin
        tlb.rsp_pa <= s1_entry.page_pa;
    end

endmodule

/* hw/vtp_req_merge.sv */
`timescale 1ns/1ps
`include "vtp_macros.svh"

// Per-port request FIFOs merged into one stream by round-robin
module vtp_req_merge
    import vtp_client_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    // Client request ports
    input  logic [`VTP_N_PORTS-1:0] lookup_en,
    input  t_vtp_lookup_req         lookup_req [`VTP_N_PORTS],
    output logic [`VTP_N_PORTS-1:0] lookup_rdy,

    // Merged stream toward the TLB stage
    output logic                    req_valid,
    output t_vtp_routed_req         req,
    input  logic                    req_ready
);

    t_vtp_lookup_req         port_first [`VTP_N_PORTS];
    logic [`VTP_N_PORTS-1:0] port_ne;
    logic [`VTP_N_PORTS-1:0] port_deq;

    t_vtp_port_idx   rr_ptr;
    t_vtp_port_idx   grant_idx;
    logic            grant_found;
    logic            grant_en;
    logic            merged_af;

    logic            win_en;
    t_vtp_routed_req win_req;

    // Input buffering, lookup_rdy is the FIFO's free-space flag
    for (genvar p = 0; p < `VTP_N_PORTS; p++)
    begin : g_in
        vtp_fifo #(
            .t_payload(t_vtp_lookup_req),
            .DEPTH(`VTP_IN_FIFO_DEPTH),
            .AF_SLACK(1)
        ) in_fifo (
            .clk,
            .reset,
            .enq_en(lookup_en[p]),
            .enq_data(lookup_req[p]),
            .not_full(lookup_rdy[p]),
            .almost_full(),
            .deq_en(port_deq[p]),
            .first(port_first[p]),
            .not_empty(port_ne[p])
        );
    end

    // First non-empty port at or after the priority pointer
    always_comb
    begin
        int cand;
        grant_found = 1'b0;
        grant_idx = rr_ptr;
        for (int i = 0; i < `VTP_N_PORTS; i++)
        begin
            cand = (int'(rr_ptr) + i) % `VTP_N_PORTS;
            if (!grant_found && port_ne[cand])
            begin
                grant_found = 1'b1;
                grant_idx = t_vtp_port_idx'(cand);
            end
        end
    end

    // Hold off while the merged FIFO is nearly full
    // One winner may still be in the register below
    assign grant_en = grant_found && !merged_af;

    always_comb
    begin
        port_deq = '0;
        if (grant_en)
        begin
            port_deq[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rr_ptr <= '0;
            win_en <= 1'b0;
        end
        else
        begin
            win_en <= grant_en;
            if (grant_en)
            begin
                // Priority passes to the port after the winner
                if (grant_idx == t_vtp_port_idx'(`VTP_N_PORTS - 1))
                begin
                    rr_ptr <= '0;
                end
                else
                begin
                    rr_ptr <= grant_idx + 1'b1;
                end
            end
        end
    end

    // Winner tagged with its port
    always_ff @(posedge clk)
    begin
        win_req.req <= port_first[grant_idx];
        win_req.port <= grant_idx;
    end

    vtp_fifo #(
        .t_payload(t_vtp_routed_req),
        .DEPTH(`VTP_IN_FIFO_DEPTH),
        .AF_SLACK(2)
    ) merged_fifo (
        .clk,
        .reset,
        .enq_en(win_en),
        .enq_data(win_req),
        .not_full(),
        .almost_full(merged_af),
        .deq_en(req_valid && req_ready),
        .first(req),
        .not_empty(req_valid)
    );

endmodule

/* hw/vtp_fifo.sv */
`timescale 1ns/1ps

// Synchronous FIFO, head entry read combinationally
// Depth must be a power of two so the pointers wrap naturally
module vtp_fifo
#(
    parameter type t_payload = logic,
    parameter int  DEPTH = 4,
    // Free slots remaining when almost_full rises
    parameter int  AF_SLACK = 1
)
(
    input  logic     clk,
    input  logic     reset,

    input  logic     enq_en,
    input  t_payload enq_data,
    output logic     not_full,
    output logic     almost_full,

    input  logic     deq_en,
    output t_payload first,
    output logic     not_empty
);

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(DEPTH);
    localparam logic [PTR_BITS:0] AF_COUNT = (PTR_BITS + 1)'(DEPTH - AF_SLACK);

    t_payload            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;

    // Storage
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq_en, deq_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign not_full = (count != FULL_COUNT);
    assign almost_full = (count >= AF_COUNT);

endmodule

/* hw/vtp_tlb_if.sv */
`timescale 1ns/1ps
`include "vtp_macros.svh"

// Lookup and fill channels of the TLB
// No ready signals, the TLB takes a lookup and a fill every cycle
interface vtp_tlb_if;

    // Lookup request
    logic                         lookup_en;
    logic [`VTP_VA_PAGE_BITS-1:0] lookup_va;

    // Lookup result, two cycles after lookup_en
    logic                         rsp_hit;
    logic                         rsp_miss;
    logic [`VTP_PA_PAGE_BITS-1:0] rsp_pa;

    // Fill from the page walker
    logic                         fill_en;
    logic [`VTP_VA_PAGE_BITS-1:0] fill_va;
    logic [`VTP_PA_PAGE_BITS-1:0] fill_pa;

    modport lookup (
        output lookup_en, lookup_va,
        input  rsp_hit, rsp_miss, rsp_pa
    );

    modport fill (
        output fill_en, fill_va, fill_pa
    );

    modport server (
        input  lookup_en, lookup_va, fill_en, fill_va, fill_pa,
        output rsp_hit, rsp_miss, rsp_pa
    );

endinterface

/* hw/vtp_tlb_pkg.sv */
`include "vtp_macros.svh"

// Types internal to the TLB and its result path
package vtp_tlb_pkg;

    localparam int VTP_TLB_IDX_BITS = $clog2(`VTP_TLB_SETS);

    typedef logic [VTP_TLB_IDX_BITS-1:0] t_vtp_tlb_idx;
    typedef logic [`VTP_VA_PAGE_BITS-VTP_TLB_IDX_BITS-1:0] t_vtp_tlb_tag;

    // One TLB entry
    typedef struct packed {
        logic                         valid;
        t_vtp_tlb_tag                 tag;
        logic [`VTP_PA_PAGE_BITS-1:0] page_pa;
    } t_vtp_tlb_entry;

    // Lookup outcome, buffered beside its request
    typedef struct packed {
        logic [`VTP_PA_PAGE_BITS-1:0] page_pa;
        logic                         hit;
    } t_vtp_tlb_result;

    // Set index is the low VA page bits
    function automatic t_vtp_tlb_idx vtp_tlb_index(input logic [`VTP_VA_PAGE_BITS-1:0] va);
        return va[VTP_TLB_IDX_BITS-1:0];
    endfunction

    // Tag is everything above the index
    function automatic t_vtp_tlb_tag vtp_tlb_tag_of(input logic [`VTP_VA_PAGE_BITS-1:0] va);
        return va[`VTP_VA_PAGE_BITS-1:VTP_TLB_IDX_BITS];
    endfunction

endpackage

/* hw/vtp_client_pkg.sv */
`include "vtp_macros.svh"

// Types seen by clients and by the request path
package vtp_client_pkg;

    typedef logic [$clog2(`VTP_N_PORTS)-1:0] t_vtp_port_idx;
    typedef logic [`VTP_VA_PAGE_BITS-1:0] t_vtp_va_page;
    typedef logic [`VTP_PA_PAGE_BITS-1:0] t_vtp_pa_page;
    typedef logic [`VTP_TAG_BITS-1:0] t_vtp_tag;

    // Lookup request from a client
    typedef struct packed {
        t_vtp_va_page page_va;
        t_vtp_tag     tag;
    } t_vtp_lookup_req;

    // Translation returned to a client
    typedef struct packed {
        t_vtp_pa_page page_pa;
        t_vtp_tag     tag;
    } t_vtp_lookup_rsp;

    // Request tagged with the port it came from
    typedef struct packed {
        t_vtp_lookup_req req;
        t_vtp_port_idx   port;
    } t_vtp_routed_req;

endpackage

/* hw/vtp_macros.svh */
`ifndef VTP_MACROS_SVH
`define VTP_MACROS_SVH

// Client ports served by one translation service
`define VTP_N_PORTS 2

// Page number widths, 4 KB pages
`define VTP_VA_PAGE_BITS 20
`define VTP_PA_PAGE_BITS 20

// Client request tag, echoed in the response
`define VTP_TAG_BITS 4

// Direct-mapped TLB entries, indexed by low VA page bits
`define VTP_TLB_SETS 16

// Buffer depths, powers of two
`define VTP_IN_FIFO_DEPTH 4
`define VTP_STAGE_FIFO_DEPTH 8
`define VTP_WALK_FIFO_DEPTH 8

`endif
